// File: all.f
+incdir+source
source/icache_pkg.sv
source/icache_if.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_fill_unit.sv
source/icache_ctrl.sv
source/icache_top.sv
test/icache_chk.sv
test/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash

# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module icache_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running after assertion errors so the summary is printed
sim_out=$(./obj_dir/Vicache_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// File: test/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tb
  import icache_pkg::*;
();

  // About 60 misses of at most 20 cycles each plus hits and reset
  localparam int unsigned max_cycles = 3000;

  logic  clk_i;
  logic  reset_i;
  logic  fetch_v_i;
  addr_t fetch_addr_i;
  logic  fencei_i;
  logic  ready_o;
  logic  data_v_o;
  word_t data_o;
  logic  fill_req_v_o;
  addr_t fill_addr_o;
  logic  fill_v_i;
  word_t fill_data_i;

  int unsigned cycle_count = 0;
  int unsigned err_count   = 0;
  int unsigned check_count = 0;
  int unsigned fill_count  = 0;
  int unsigned stall_count = 0;
  int unsigned model_fills = 0;
  int unsigned test_count  = 0;
  int unsigned errs_start;
  int unsigned fills_start;
  int unsigned stalls_start;
  int unsigned model_start;
  string       cur_test = "reset";

  addr_t fetch_q [$];
  addr_t exp_data_q [$];
  addr_t exp_fill_q [$];
  int unsigned gaps [256];
  int unsigned gap_idx = 0;

  // Reference model of tags, valid bits and LRU
  tag_t                    model_tag [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0] model_valid [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] model_lru;

  icache_top i_icache_top (.*);

  bind icache_top icache_chk i_icache_chk (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fill_req_v_i (fill_req_v_o),
    .fill_v_i     (fill_v_i),
    .data_v_i     (data_v_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_count <= cycle_count + 1;

  initial
  begin
    wait (cycle_count >= max_cycles);
    $display("Timeout, the run did not finish within %0d cycles", max_cycles);
    $display("Done: errors found");
    $finish;
  end

  function automatic word_t backing_word(addr_t a);
    return a ^ 32'h5A5A_0000;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Backing memory and response monitor
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    addr_t base;
    fill_v_i    = 1'b0;
    fill_data_i = '0;
    forever
    begin
      @(negedge clk_i);
      if (fill_req_v_o === 1'b1)
      begin
        base = fill_addr_o;
        for (int b = 0; b < `ICACHE_BLOCK_WORDS; b++)
        begin
          repeat (gaps[gap_idx % 256]) @(negedge clk_i);
          gap_idx++;
          fill_v_i    = 1'b1;
          fill_data_i = backing_word(base + addr_t'(4 * b));
          @(negedge clk_i);
          fill_v_i = 1'b0;
        end
      end
    end
  end

  always @(negedge clk_i)
  begin
    addr_t a;
    if (data_v_o === 1'b1)
    begin
      check_count++;
      assert (exp_data_q.size() != 0)
      else
      begin
        $display("Test %s returned data with no fetch outstanding", cur_test);
        err_count++;
      end
      if (exp_data_q.size() != 0)
      begin
        a = exp_data_q.pop_front();
        assert (data_o == backing_word(a))
        else
        begin
          $display("ERR %s expected %h actual %h", cur_test, backing_word(a), data_o);
          err_count++;
        end
      end
    end
    if (fill_req_v_o === 1'b1)
    begin
      fill_count++;
      check_count++;
      assert (exp_fill_q.size() != 0)
      else
      begin
        $display("Test %s issued a fill request on a hit", cur_test);
        err_count++;
      end
      if (exp_fill_q.size() != 0)
      begin
        a = exp_fill_q.pop_front();
        assert (fill_addr_o == a)
        else
        begin
          $display("ERR %s expected %h actual %h", cur_test, a, fill_addr_o);
          err_count++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_access(input addr_t a);
    index_t idx;
    tag_t   tg;
    way_t   way;
    logic   hit;
    idx = a[7:4];
    tg  = a[31:8];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (model_valid[idx][w] && (model_tag[w][idx] == tg))
      begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    if (!hit)
    begin
      // Lowest invalid way first and the LRU way otherwise
      if (!model_valid[idx][0])
        way = 1'b0;
      else if (!model_valid[idx][1])
        way = 1'b1;
      else
        way = model_lru[idx];
      model_valid[idx][way] = 1'b1;
      model_tag[way][idx]   = tg;
      exp_fill_q.push_back({a[31:4], 4'h0});
      model_fills++;
    end
    model_lru[idx] = ~way;
    exp_data_q.push_back(a);
  endtask

  // Sends the queued fetches one per cycle whenever ready_o allows
  task automatic drive_fetches();
    while (fetch_q.size() != 0)
    begin
      @(negedge clk_i);
      if (ready_o)
      begin
        fetch_v_i    = 1'b1;
        fetch_addr_i = fetch_q.pop_front();
        model_access(fetch_addr_i);
      end
      else
      begin
        fetch_v_i = 1'b0;
        stall_count++;
      end
    end
    @(negedge clk_i);
    fetch_v_i = 1'b0;
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    errs_start   = err_count;
    fills_start  = fill_count;
    stalls_start = stall_count;
    model_start  = model_fills;
    test_count++;
  endtask

  task automatic end_test(input int unsigned exp_fills);
    int unsigned fills;
    while (exp_data_q.size() != 0)
      @(negedge clk_i);
    repeat (3) @(negedge clk_i);
    fills = fill_count - fills_start;
    check_count++;
    assert (fills == exp_fills)
    else
    begin
      $display("ERR %s expected %0d actual %0d", cur_test, exp_fills, fills);
      err_count++;
    end
    $display("Test %s finished with %0d errors", cur_test, err_count - errs_start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic cold_fetch_test();
    begin_test("cold_fetch");
    @(negedge clk_i);
    check_count++;
    assert (ready_o === 1'b1 && data_v_o === 1'b0)
    else
    begin
      $display("Ready did not rise on the first clock after reset");
      err_count++;
    end
    fetch_q.push_back(32'h0000_0048);
    drive_fetches();
    end_test(1);
  endtask

  task automatic burst_hit_test();
    begin_test("burst_hit");
    for (int w = 0; w < `ICACHE_BLOCK_WORDS; w++)
      fetch_q.push_back(32'h0000_0040 + addr_t'(4 * w));
    drive_fetches();
    check_count++;
    assert (stall_count == stalls_start)
    else
    begin
      $display("Fetches to a cached block were not accepted every cycle");
      err_count++;
    end
    end_test(0);
  endtask

  // Three tags in set 5 where C must replace B
  task automatic lru_test();
    begin_test("lru_evict");
    fetch_q.push_back(32'h0000_1050);
    fetch_q.push_back(32'h0000_2054);
    fetch_q.push_back(32'h0000_1058);
    fetch_q.push_back(32'h0000_305C);
    fetch_q.push_back(32'h0000_1054);
    drive_fetches();
    end_test(3);
  endtask

  task automatic fence_test();
    begin_test("fence");
    @(negedge clk_i);
    while (!ready_o)
      @(negedge clk_i);
    fencei_i    = 1'b1;
    model_valid = '{default: '0};
    @(negedge clk_i);
    fencei_i = 1'b0;
    fetch_q.push_back(32'h0000_0044);
    drive_fetches();
    end_test(1);
  endtask

  task automatic miss_then_fetch_test();
    begin_test("miss_then_fetch");
    fetch_q.push_back(32'h0000_6068);
    fetch_q.push_back(32'h0000_004C);
    drive_fetches();
    end_test(1);
  endtask

  // Four tags per set so that replacement by LRU is exercised
  task automatic random_test();
    begin_test("random");
    for (int i = 0; i < 48; i++)
      fetch_q.push_back(32'h0000_8000 | (($urandom % 256) << 2));
    drive_fetches();
    end_test(model_fills - model_start);
  endtask

  initial
  begin
    int unsigned total;
    void'($urandom(32'h4b38_8800));
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_addr_i = '0;
    fencei_i     = 1'b0;
    model_valid  = '{default: '0};
    model_lru    = '0;
    for (int i = 0; i < 256; i++)
      gaps[i] = $urandom % 4;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    cold_fetch_test();
    burst_hit_test();
    lru_test();
    fence_test();
    miss_then_fetch_test();
    random_test();

    total = err_count + i_icache_top.i_icache_chk.fail_count;
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, total);
    if (total == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: test/icache_chk.sv
`timescale 1ns/1ps

module icache_chk
(
  input logic clk_i,
  input logic reset_i,
  input logic fill_req_v_i,
  input logic fill_v_i,
  input logic data_v_i
);

  int unsigned fail_count = 0;

  // A block fill is outstanding from its request until the fourth beat
  logic       pend_r;
  logic [1:0] beat_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pend_r <= 1'b0;
      beat_r <= '0;
    end
    else
    begin
      // The first beat may arrive in the request cycle
      if (fill_v_i && (pend_r || fill_req_v_i))
        beat_r <= beat_r + 1'b1;
      if (fill_req_v_i)
        pend_r <= 1'b1;
      else if (fill_v_i && pend_r && (beat_r == 2'd3))
        pend_r <= 1'b0;
    end
  end

  req_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_req_v_i |=> !fill_req_v_i)
  else
  begin
    $error("Fill request held high for two cycles");
    fail_count++;
  end

  // Output register is cleared by the first reset edge
  no_data_in_reset: assert property (@(posedge clk_i)
    $past(reset_i) && reset_i |-> !data_v_i)
  else
  begin
    $error("Data valid while reset is high");
    fail_count++;
  end

  one_fill_at_a_time: assert property (@(posedge clk_i) disable iff (reset_i)
    fill_req_v_i |-> !pend_r)
  else
  begin
    $error("Fill request issued while a fill is outstanding");
    fail_count++;
  end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,

  // Fetch side
  input  logic  fetch_v_i,
  input  addr_t fetch_addr_i,
  input  logic  fencei_i,
  output logic  ready_o,
  output logic  data_v_o,
  output word_t data_o,

  // Backing memory side
  output logic  fill_req_v_o,
  output addr_t fill_addr_o,
  input  logic  fill_v_i,
  input  word_t fill_data_i
);

  lookup_if lk ();
  fill_if   fw ();

  logic  miss_v;
  addr_t miss_addr;

  icache_ctrl i_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_v_i    (fetch_v_i),
    .fetch_addr_i (fetch_addr_i),
    .fencei_i     (fencei_i),
    .ready_o      (ready_o),
    .data_v_o     (data_v_o),
    .data_o       (data_o),
    .lk           (lk.ctrl),
    .fill_done_i  (fw.done),
    .miss_v_o     (miss_v),
    .miss_addr_o  (miss_addr)
  );

  icache_tag_array i_tag_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .lk      (lk.tag),
    .fw      (fw.tag)
  );

  icache_data_array i_data_array (
    .clk_i (clk_i),
    .lk    (lk.data),
    .fw    (fw.data)
  );

  // Victim is sampled by the fill unit in the miss cycle
  icache_fill_unit i_fill_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_v_i     (miss_v),
    .miss_addr_i  (miss_addr),
    .victim_way_i (lk.victim_way),
    .fill_req_v_o (fill_req_v_o),
    .fill_addr_o  (fill_addr_o),
    .fill_v_i     (fill_v_i),
    .fill_data_i  (fill_data_i),
    .fw           (fw.fill)
  );

endmodule

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     fetch_v_i,
  input  addr_t    fetch_addr_i,
  input  logic     fencei_i,
  output logic     ready_o,
  output logic     data_v_o,
  output word_t    data_o,
  lookup_if.ctrl   lk,
  input  logic     fill_done_i,
  output logic     miss_v_o,
  output addr_t    miss_addr_o
);

  ctrl_state_e state_r;
  ctrl_state_e state_n;

  // Goes high one clock after reset is released
  logic  up_r;

  // Verify stage, the fetch whose array read is on the array outputs
  logic  vs_v_r;
  addr_t vs_addr_r;

  logic  out_v_r;
  word_t out_data_r;

  logic  is_ready;
  logic  is_recover;
  logic  miss;
  logic  accept;

  assign is_ready   = (state_r == s_ready);
  assign is_recover = (state_r == s_recover);

  ////////////////////////////////////////////////////////////////////////////
  // Lookup stage
  ////////////////////////////////////////////////////////////////////////////

  // Compare results are only trusted in s_ready
  assign miss    = is_ready & vs_v_r & ~lk.hit;
  assign ready_o = up_r & is_ready & ~miss;
  assign accept  = fetch_v_i & ready_o;

  assign lk.flush = fencei_i & ready_o;

  // Recover re-reads the set of the fetch held in the verify stage
  assign lk.rd_v     = accept | is_recover;
  assign lk.rd_index = is_recover ? addr_index(vs_addr_r) : addr_index(fetch_addr_i);

  ////////////////////////////////////////////////////////////////////////////
  // Verify stage
  ////////////////////////////////////////////////////////////////////////////

  assign lk.cmp_tag   = addr_tag(vs_addr_r);
  assign lk.cmp_woff  = addr_woff(vs_addr_r);
  assign lk.hit_upd_v = is_ready & vs_v_r & lk.hit;

  assign miss_v_o    = miss;
  assign miss_addr_o = vs_addr_r;

  assign data_v_o = out_v_r;
  assign data_o   = out_data_r;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      s_ready:
        if (miss)
          state_n = s_miss;
      s_miss:
        if (fill_done_i)
          state_n = s_recover;
      s_recover:
        state_n = s_ready;
      default:
        state_n = s_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= s_ready;
      up_r    <= 1'b0;
      vs_v_r  <= 1'b0;
      out_v_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      up_r    <= 1'b1;
      out_v_r <= lk.hit_upd_v;
      // Both stages stay frozen from the miss until recover is done
      if (is_ready & ~miss)
        vs_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      vs_addr_r <= fetch_addr_i;
    if (lk.hit_upd_v)
      out_data_r <= lk.hit_word;
  end

endmodule

// File: source/icache_fill_unit.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_fill_unit
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   miss_v_i,
  input  addr_t  miss_addr_i,
  input  way_t   victim_way_i,
  output logic   fill_req_v_o,
  output addr_t  fill_addr_o,
  input  logic   fill_v_i,
  input  word_t  fill_data_i,
  fill_if.fill   fw
);

  logic  req_v_r;
  logic  busy_r;
  woff_t beat_r;

  addr_t blk_addr_r;
  way_t  way_r;

  logic  beat_v;
  logic  beat_last;

  assign beat_v    = fill_v_i & busy_r;
  assign beat_last = beat_v & (beat_r == woff_t'(`ICACHE_BLOCK_WORDS - 1));

  // Request goes out the cycle after the miss
  assign fill_req_v_o = req_v_r;
  assign fill_addr_o  = blk_addr_r;

  // Beats are written in arrival order
  assign fw.wr_v     = beat_v;
  assign fw.wr_index = addr_index(blk_addr_r);
  assign fw.wr_tag   = addr_tag(blk_addr_r);
  assign fw.wr_way   = way_r;
  assign fw.wr_woff  = beat_r;
  assign fw.wr_data  = fill_data_i;
  assign fw.wr_last  = beat_last;
  assign fw.done     = beat_last;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_r <= 1'b0;
      busy_r  <= 1'b0;
      beat_r  <= '0;
    end
    else
    begin
      req_v_r <= miss_v_i;
      if (miss_v_i)
      begin
        busy_r <= 1'b1;
        beat_r <= '0;
      end
      else if (beat_v)
      begin
        beat_r <= beat_r + 1'b1;
        if (beat_last)
          busy_r <= 1'b0;
      end
    end
  end

  // Missed line and the way it will replace
  always_ff @(posedge clk_i)
  begin
    if (miss_v_i)
    begin
      blk_addr_r <= block_addr(miss_addr_i);
      way_r      <= victim_way_i;
    end
  end

endmodule

// File: source/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_array
  import icache_pkg::*;
(
  input  logic   clk_i,
  lookup_if.data lk,
  fill_if.data   fw
);

  localparam int unsigned depth = `ICACHE_SETS * `ICACHE_BLOCK_WORDS;

  // One word per entry, addressed by set index and word offset
  word_t mem [`ICACHE_WAYS][depth];

  // Whole block of every way from the last read
  word_t blk_q [`ICACHE_WAYS][`ICACHE_BLOCK_WORDS];

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // The word offset is not known at read time, so all words are read
  always_ff @(posedge clk_i)
  begin
    if (lk.rd_v)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        for (int b = 0; b < `ICACHE_BLOCK_WORDS; b++)
        begin
          blk_q[w][b] <= mem[w][{lk.rd_index, woff_t'(b)}];
        end
      end
    end
  end

  // One beat per write
  always_ff @(posedge clk_i)
  begin
    if (fw.wr_v)
      mem[fw.wr_way][{fw.wr_index, fw.wr_woff}] <= fw.wr_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word select
  ////////////////////////////////////////////////////////////////////////////

  assign lk.hit_word = blk_q[lk.hit_way][lk.cmp_woff];

endmodule

// File: source/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  lookup_if.tag lk,
  fill_if.tag   fw
);

  tag_t                    tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  tag_t                    tag_q [`ICACHE_WAYS];
  index_t                  idx_r;

  // Valid bits per set and way, and the LRU way per set
  logic [`ICACHE_WAYS-1:0] valid_r [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] lru_r;

  logic [`ICACHE_WAYS-1:0] way_v;
  logic [`ICACHE_WAYS-1:0] hit_vec;

  ////////////////////////////////////////////////////////////////////////////
  // Tag memory
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (lk.rd_v)
    begin
      idx_r <= lk.rd_index;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        tag_q[w] <= tag_mem[w][lk.rd_index];
      end
    end
    if (fw.wr_last)
      tag_mem[fw.wr_way][fw.wr_index] <= fw.wr_tag;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and LRU state
  ////////////////////////////////////////////////////////////////////////////

  // Flush wipes every line at once
  always_ff @(posedge clk_i)
  begin
    if (reset_i || lk.flush)
      valid_r <= '{default: '0};
    else if (fw.wr_last)
      valid_r[fw.wr_index][fw.wr_way] <= 1'b1;
  end

  // LRU points away from the way last touched
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (fw.wr_last)
      lru_r[fw.wr_index] <= ~fw.wr_way;
    else if (lk.hit_upd_v)
      lru_r[idx_r] <= ~lk.hit_way;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hit detection and victim choice
  ////////////////////////////////////////////////////////////////////////////

  // Valid bits are read live so a flush hits lookups already in flight
  assign way_v = valid_r[idx_r];

  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      hit_vec[w] = way_v[w] && (tag_q[w] == lk.cmp_tag);
    end
  end

  assign lk.hit     = |hit_vec;
  assign lk.hit_way = way_t'(hit_vec[1]);

  always_comb
  begin
    if (!way_v[0])
      lk.victim_way = 1'b0;
    else if (!way_v[1])
      lk.victim_way = 1'b1;
    else
      lk.victim_way = lru_r[idx_r];
  end

endmodule

// File: source/icache_if.sv
`timescale 1ns/1ps

// Read, compare and select between the controller and the two arrays
interface lookup_if
  import icache_pkg::*;
();

  logic   rd_v;
  index_t rd_index;
  tag_t   cmp_tag;
  woff_t  cmp_woff;
  logic   hit_upd_v;
  logic   flush;
  logic   hit;
  way_t   hit_way;
  way_t   victim_way;
  word_t  hit_word;

  modport ctrl (
    output rd_v, rd_index, cmp_tag, cmp_woff, hit_upd_v, flush,
    input  hit, hit_word
  );

  modport tag (
    input  rd_v, rd_index, cmp_tag, hit_upd_v, flush,
    output hit, hit_way, victim_way
  );

  modport data (
    input  rd_v, rd_index, cmp_woff, hit_way,
    output hit_word
  );

endinterface

// Block refill writes from the fill unit into both arrays
interface fill_if
  import icache_pkg::*;
();

  logic   wr_v;
  index_t wr_index;
  tag_t   wr_tag;
  way_t   wr_way;
  woff_t  wr_woff;
  word_t  wr_data;
  logic   wr_last;
  logic   done;

  modport fill (
    output wr_v, wr_index, wr_tag, wr_way, wr_woff, wr_data, wr_last, done
  );

  modport tag (
    input wr_index, wr_tag, wr_way, wr_last
  );

  modport data (
    input wr_v, wr_index, wr_way, wr_woff, wr_data
  );

endinterface

// File: source/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

  // Field widths of a physical byte address
  localparam int unsigned addr_w  = `ICACHE_ADDR_W;
  localparam int unsigned boff_w  = $clog2(`ICACHE_WORD_W / 8);
  localparam int unsigned woff_w  = $clog2(`ICACHE_BLOCK_WORDS);
  localparam int unsigned index_w = $clog2(`ICACHE_SETS);
  localparam int unsigned tag_w   = addr_w - index_w - woff_w - boff_w;
  localparam int unsigned way_w   = $clog2(`ICACHE_WAYS);

  typedef logic [addr_w-1:0]         addr_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;
  typedef logic [tag_w-1:0]          tag_t;
  typedef logic [index_w-1:0]        index_t;
  typedef logic [woff_w-1:0]         woff_t;
  typedef logic [way_w-1:0]          way_t;

  typedef enum logic [1:0]
  {
    s_ready,
    s_miss,
    s_recover
  } ctrl_state_e;

  function automatic tag_t addr_tag(addr_t a);
    return a[addr_w-1 -: tag_w];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[boff_w + woff_w +: index_w];
  endfunction

  function automatic woff_t addr_woff(addr_t a);
    return a[boff_w +: woff_w];
  endfunction

  // Address of word 0 of the block
  function automatic addr_t block_addr(addr_t a);
    return {a[addr_w-1:boff_w + woff_w], {(boff_w + woff_w){1'b0}}};
  endfunction

endpackage

// File: source/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Byte address width of the fetch port
`define ICACHE_ADDR_W 32

// Width of one instruction word
`define ICACHE_WORD_W 32

// Number of sets
`define ICACHE_SETS 16

// Associativity
// Victim selection only handles two ways
`define ICACHE_WAYS 2

// Words in one cache block
`define ICACHE_BLOCK_WORDS 4

`endif
